/* common/sd_cmd_pkg.sv */
`default_nettype none

package sd_cmd_pkg;

    // ========================================
    // Vector types
    // ========================================

    // SD command number, six bits in the frame
    typedef logic [5:0] cmd_index_t;

    // Command argument or R1 response payload
    typedef logic [31:0] cmd_arg_t;

    // CRC7 remainder, x^7 + x^3 + 1
    typedef logic [6:0] crc7_t;

    // ========================================
    // Command indices
    // ========================================

    // Reset card to idle, no response
    localparam cmd_index_t CMD_GO_IDLE = 6'd0;
    // Voltage check with echo pattern
    localparam cmd_index_t CMD_SEND_IF_COND = 6'd8;
    // Prefix for application commands
    localparam cmd_index_t CMD_APP_CMD = 6'd55;
    // ACMD41, host capacity and voltage window
    localparam cmd_index_t CMD_SD_SEND_OP_COND = 6'd41;

    // Entries in the power-up table
    localparam int INIT_TABLE_LEN = 4;

    // ========================================
    // Engine states
    // ========================================

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_TX,
        ENG_WAIT_START,
        ENG_RX,
        ENG_GAP
    } engine_state_t;

endpackage

`default_nettype wire

/* sd_cmd/sd_crc7.sv */
`default_nettype none

module sd_crc7
    import sd_cmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst_,
    input  logic  clear,
    input  logic  enable,
    input  logic  din,
    output crc7_t crc
);

    // Feedback is the incoming bit against the remainder MSB
    logic  feedback;
    crc7_t crc_next;

    assign feedback = din ^ crc[6];

    // Taps at x^3 and x^0
    assign crc_next = {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            crc <= '0;
        end else if (clear) begin
            // Start of a new frame
            crc <= '0;
        end else if (enable) begin
            crc <= crc_next;
        end
    end

endmodule

`default_nettype wire

/* sd_cmd/sd_cmd_engine.sv */
`default_nettype none

module sd_cmd_engine
    import sd_cmd_pkg::*;
#(
    parameter int CLK_DIV_HALF = 4,
    parameter int RESP_TIMEOUT = 64
) (
    input  logic       clk,
    input  logic       rst_,
    input  logic       empty,
    input  cmd_index_t head_index,
    input  cmd_arg_t   head_arg,
    input  logic       head_resp,
    input  logic       cmd_in,
    output logic       pop,
    output logic       sd_clk,
    output logic       cmd_out,
    output logic       cmd_oe,
    output logic       resp_valid,
    output cmd_index_t resp_index,
    output cmd_arg_t   resp_arg,
    output logic       resp_crc_ok,
    output logic       resp_timeout,
    output logic       cmd_done
);

    localparam int DIV_W = $clog2(CLK_DIV_HALF + 1);
    localparam int TO_W = $clog2(RESP_TIMEOUT + 1);

    engine_state_t    state;
    logic [DIV_W-1:0] div_cnt;
    logic             half_tick;
    logic             clk_rise;
    logic             clk_fall;
    logic [5:0]       bit_cnt;
    logic [TO_W-1:0]  to_cnt;
    logic             expect_resp;
    logic [39:0]      tx_shift;
    logic [47:0]      rx_shift;
    logic             load;
    logic             rx_take;
    logic             tx_crc_en;
    logic             rx_crc_en;
    crc7_t            tx_crc;
    crc7_t            rx_crc;

    // ========================================
    // sd_clk divider
    // ========================================

    // Half period ends after CLK_DIV_HALF clk cycles
    assign half_tick = (state != ENG_IDLE) && (div_cnt == DIV_W'(CLK_DIV_HALF - 1));
    assign clk_rise = half_tick && !sd_clk;
    assign clk_fall = half_tick && sd_clk;

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            div_cnt <= '0;
            sd_clk <= 1'b0;
        end else if (state == ENG_IDLE) begin
            // Clock parked low between commands
            div_cnt <= '0;
            sd_clk <= 1'b0;
        end else if (half_tick) begin
            div_cnt <= '0;
            sd_clk <= !sd_clk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ========================================
    // CRC units
    // ========================================

    // Head is captured in the pop cycle
    assign load = (state == ENG_IDLE) && pop;

    // Card samples on the rising edge, so feed the CRC there too
    assign tx_crc_en = (state == ENG_TX) && clk_rise && (bit_cnt < 6'd40);

    // Start bit seen in wait state, or any bit of the response body
    assign rx_take = clk_rise && ((state == ENG_RX) || (state == ENG_WAIT_START && !cmd_in));
    assign rx_crc_en = rx_take && (bit_cnt < 6'd40);

    sd_crc7 tx_crc_i (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (load),
        .enable (tx_crc_en),
        .din    (tx_shift[39]),
        .crc    (tx_crc)
    );

    sd_crc7 rx_crc_i (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (load),
        .enable (rx_crc_en),
        .din    (cmd_in),
        .crc    (rx_crc)
    );

    // ========================================
    // Shift registers
    // ========================================

    // MSB first on the line
    assign cmd_out = tx_shift[39];

    always_ff @(posedge clk) begin
        if (load) begin
            // Start bit, host transmission bit, index, argument
            tx_shift <= {2'b01, head_index, head_arg};
        end else if (state == ENG_TX && clk_fall) begin
            if (bit_cnt == 6'd39) begin
                // Tail of frame: CRC then end bit
                tx_shift <= {tx_crc, 1'b1, 32'd0};
            end else begin
                tx_shift <= {tx_shift[38:0], 1'b1};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_take) begin
            rx_shift <= {rx_shift[46:0], cmd_in};
        end
    end

    // R1 layout, valid while resp_valid is high
    assign resp_index = rx_shift[45:40];
    assign resp_arg = rx_shift[39:8];
    assign resp_crc_ok = (rx_crc == rx_shift[7:1]) && rx_shift[0];

    // ========================================
    // Command FSM
    // ========================================

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            state <= ENG_IDLE;
            pop <= 1'b0;
            cmd_oe <= 1'b0;
            bit_cnt <= '0;
            to_cnt <= '0;
            expect_resp <= 1'b0;
            resp_valid <= 1'b0;
            resp_timeout <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            // Strobes default low
            pop <= 1'b0;
            resp_valid <= 1'b0;
            resp_timeout <= 1'b0;
            cmd_done <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (pop) begin
                        expect_resp <= head_resp;
                        cmd_oe <= 1'b1;
                        bit_cnt <= '0;
                        state <= ENG_TX;
                    end else if (!empty) begin
                        pop <= 1'b1;
                    end
                end
                ENG_TX: begin
                    // Bits advance on the falling edge
                    if (clk_fall) begin
                        if (bit_cnt == 6'd47) begin
                            cmd_oe <= 1'b0;
                            bit_cnt <= '0;
                            to_cnt <= '0;
                            state <= expect_resp ? ENG_WAIT_START : ENG_GAP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ENG_WAIT_START: begin
                    if (clk_rise) begin
                        if (!cmd_in) begin
                            // Start bit already counted as bit 0
                            bit_cnt <= 6'd1;
                            state <= ENG_RX;
                        end else if (to_cnt == TO_W'(RESP_TIMEOUT - 1)) begin
                            resp_timeout <= 1'b1;
                            bit_cnt <= '0;
                            state <= ENG_GAP;
                        end else begin
                            to_cnt <= to_cnt + 1'b1;
                        end
                    end
                end
                ENG_RX: begin
                    if (clk_rise) begin
                        if (bit_cnt == 6'd47) begin
                            resp_valid <= 1'b1;
                            bit_cnt <= '0;
                            state <= ENG_GAP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ENG_GAP: begin
                    // Eight rising edges, then park at the next fall
                    if (clk_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (clk_fall && bit_cnt == 6'd8) begin
                        cmd_done <= 1'b1;
                        state <= ENG_IDLE;
                    end
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/cmd_queue.sv */
`default_nettype none

module cmd_queue
    import sd_cmd_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst_,
    input  logic       push,
    input  cmd_index_t push_index,
    input  cmd_arg_t   push_arg,
    input  logic       push_resp,
    input  logic       pop,
    output logic       full,
    output logic       empty,
    output cmd_index_t head_index,
    output cmd_arg_t   head_arg,
    output logic       head_resp
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Entry storage
    cmd_index_t       mem_index [QUEUE_DEPTH];
    cmd_arg_t         mem_arg [QUEUE_DEPTH];
    logic             mem_resp [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full = (count == CNT_W'(QUEUE_DEPTH));
    assign empty = (count == '0);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // Show-ahead head
    assign head_index = mem_index[rd_ptr];
    assign head_arg = mem_arg[rd_ptr];
    assign head_resp = mem_resp[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_index[wr_ptr] <= push_index;
            mem_arg[wr_ptr] <= push_arg;
            mem_resp[wr_ptr] <= push_resp;
        end
    end

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // Pointers wrap at depth, which need not be a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/init_sequencer.sv */
`default_nettype none

module init_sequencer
    import sd_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_,
    input  logic       start,
    input  logic       full,
    output logic       push,
    output cmd_index_t push_index,
    output cmd_arg_t   push_arg,
    output logic       push_resp,
    output logic       seq_done
);

    localparam int PTR_W = $clog2(INIT_TABLE_LEN);

    logic             busy;
    logic [PTR_W-1:0] ptr;

    // Push whenever armed and the queue has room
    assign push = busy && !full;

    // ========================================
    // Power-up table
    // ========================================

    always_comb begin
        case (ptr)
            // Software reset, card stays silent
            PTR_W'(0): begin
                push_index = CMD_GO_IDLE;
                push_arg = 32'h0000_0000;
                push_resp = 1'b0;
            end
            // 2.7-3.6 V window, check pattern AA
            PTR_W'(1): begin
                push_index = CMD_SEND_IF_COND;
                push_arg = 32'h0000_01AA;
                push_resp = 1'b1;
            end
            // RCA zero before card is addressed
            PTR_W'(2): begin
                push_index = CMD_APP_CMD;
                push_arg = 32'h0000_0000;
                push_resp = 1'b1;
            end
            // HCS set, 3.2-3.4 V
            default: begin
                push_index = CMD_SD_SEND_OP_COND;
                push_arg = 32'h4030_0000;
                push_resp = 1'b1;
            end
        endcase
    end

    // ========================================
    // Table walk
    // ========================================

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            busy <= 1'b0;
            ptr <= '0;
            seq_done <= 1'b0;
        end else begin
            seq_done <= 1'b0;
            if (!busy) begin
                // Start ignored while running
                if (start) begin
                    busy <= 1'b1;
                    ptr <= '0;
                end
            end else if (push) begin
                if (ptr == PTR_W'(INIT_TABLE_LEN - 1)) begin
                    busy <= 1'b0;
                    ptr <= '0;
                    seq_done <= 1'b1;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/sd_cmd_top.sv */
`default_nettype none

module sd_cmd_top
    import sd_cmd_pkg::*;
#(
    parameter int CLK_DIV_HALF = 4,
    parameter int QUEUE_DEPTH = 4,
    parameter int RESP_TIMEOUT = 64
) (
    input  logic       clk,
    input  logic       rst_,
    input  logic       start,
    inout  wire        sd_cmd,
    output logic       sd_clk,
    output logic       resp_valid,
    output cmd_index_t resp_index,
    output cmd_arg_t   resp_arg,
    output logic       resp_crc_ok,
    output logic       resp_timeout,
    output logic       cmd_done,
    output logic       seq_done
);

    // Sequencer to queue
    logic       push;
    cmd_index_t push_index;
    cmd_arg_t   push_arg;
    logic       push_resp;
    logic       full;

    // Queue to engine
    logic       pop;
    logic       empty;
    cmd_index_t head_index;
    cmd_arg_t   head_arg;
    logic       head_resp;

    // Command pin
    logic cmd_out;
    logic cmd_oe;
    logic cmd_in;

    // ========================================
    // Pin tristate
    // ========================================

    // Released line is pulled up on the board
    assign sd_cmd = cmd_oe ? cmd_out : 1'bz;
    assign cmd_in = sd_cmd;

    init_sequencer init_sequencer_i (
        .clk        (clk),
        .rst_       (rst_),
        .start      (start),
        .full       (full),
        .push       (push),
        .push_index (push_index),
        .push_arg   (push_arg),
        .push_resp  (push_resp),
        .seq_done   (seq_done)
    );

    cmd_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) cmd_queue_i (
        .clk        (clk),
        .rst_       (rst_),
        .push       (push),
        .push_index (push_index),
        .push_arg   (push_arg),
        .push_resp  (push_resp),
        .pop        (pop),
        .full       (full),
        .empty      (empty),
        .head_index (head_index),
        .head_arg   (head_arg),
        .head_resp  (head_resp)
    );

    sd_cmd_engine #(
        .CLK_DIV_HALF (CLK_DIV_HALF),
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) sd_cmd_engine_i (
        .clk          (clk),
        .rst_         (rst_),
        .empty        (empty),
        .head_index   (head_index),
        .head_arg     (head_arg),
        .head_resp    (head_resp),
        .cmd_in       (cmd_in),
        .pop          (pop),
        .sd_clk       (sd_clk),
        .cmd_out      (cmd_out),
        .cmd_oe       (cmd_oe),
        .resp_valid   (resp_valid),
        .resp_index   (resp_index),
        .resp_arg     (resp_arg),
        .resp_crc_ok  (resp_crc_ok),
        .resp_timeout (resp_timeout),
        .cmd_done     (cmd_done)
    );

endmodule

`default_nettype wire

/* tb/sd_card_model.sv */
`default_nettype none

module sd_card_model
    import sd_cmd_pkg::*;
(
    input  wire        sd_clk,
    inout  wire        sd_cmd,
    input  logic       corrupt,
    input  logic       silent,
    output int         frame_count,
    output cmd_index_t rx_index,
    output cmd_arg_t   rx_arg,
    output logic       rx_crc_ok,
    output logic       rx_end_ok
);

    timeunit 1ns;
    timeprecision 100ps;

    logic        drive_oe = 1'b0;
    logic        drive_bit = 1'b1;
    logic [47:0] frame;
    logic [47:0] reply;

    // Card side of the open-drain style line
    assign sd_cmd = drive_oe ? drive_bit : 1'bz;

    // Bitwise CRC7 over the first 40 frame bits, MSB first
    function automatic crc7_t crc7_of(input logic [39:0] bits);
        crc7_t crc;
        logic  fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    // ========================================
    // Frame decode and reply
    // ========================================

    initial begin
        frame_count = 0;
        rx_index = '0;
        rx_arg = '0;
        rx_crc_ok = 1'b0;
        rx_end_ok = 1'b0;
        forever begin
            @(posedge sd_clk);
            // Low line at a rising edge is a start bit
            if (sd_cmd == 1'b0) begin
                frame[47] = 1'b0;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk);
                    frame[i] = sd_cmd;
                end
                rx_index = frame[45:40];
                rx_arg = frame[39:8];
                rx_crc_ok = (crc7_of(frame[47:8]) == frame[7:1]);
                rx_end_ok = frame[0];
                frame_count++;
                // CMD0 never answers
                if (rx_index != CMD_GO_IDLE && !silent) begin
                    reply[47:8] = {2'b00, rx_index, rx_arg};
                    // Lowest CRC bit flipped on request
                    reply[7:1] = crc7_of(reply[47:8]) ^ {6'd0, corrupt};
                    reply[0] = 1'b1;
                    // Host releases at the first fall, reply two cycles on
                    repeat (2) @(negedge sd_clk);
                    for (int i = 47; i >= 0; i--) begin
                        drive_bit = reply[i];
                        drive_oe = 1'b1;
                        @(negedge sd_clk);
                    end
                    drive_oe = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/sd_cmd_tb.sv */
`default_nettype none

module sd_cmd_tb
    import sd_cmd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_DIV_HALF = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int RESP_TIMEOUT = 64;
    // Frame, wait window, reply and gap, with margin
    localparam int CMD_LIMIT = 2 * CLK_DIV_HALF * (120 + RESP_TIMEOUT) + 50;

    // Test ids
    localparam int T_RESET = 0;
    localparam int T_FRAME = 1;
    localparam int T_RESP = 2;
    localparam int T_CRC = 3;
    localparam int T_TIMEOUT = 4;
    localparam int T_CLOCK = 5;

    logic       clk = 1'b0;
    logic       rst_;
    logic       start;
    logic       corrupt;
    logic       silent;
    logic       started;
    wire        sd_cmd;
    logic       sd_clk;
    logic       resp_valid;
    cmd_index_t resp_index;
    cmd_arg_t   resp_arg;
    logic       resp_crc_ok;
    logic       resp_timeout;
    logic       cmd_done;
    logic       seq_done;

    // Card model outputs
    int         frame_count;
    cmd_index_t rx_index;
    cmd_arg_t   rx_arg;
    logic       rx_crc_ok;
    logic       rx_end_ok;

    // Bookkeeping
    int          errs [6];
    string       test_names [6] = '{"reset_state", "frame_contents", "response_path",
                                    "crc_failure", "timeout", "clock_shape"};
    int          seq_count = 0;
    int          done_count = 0;
    int          gap_checked = 0;
    int          quiet_rises = 0;
    int          phase_len = 0;
    logic        last_sd_clk = 1'b0;
    logic        low_parked = 1'b1;
    logic [31:0] lfsr_state = 32'h45ce;

    // Power-up table as the card should see it
    cmd_index_t exp_index [INIT_TABLE_LEN] = '{CMD_GO_IDLE, CMD_SEND_IF_COND,
                                               CMD_APP_CMD, CMD_SD_SEND_OP_COND};
    cmd_arg_t   exp_arg [INIT_TABLE_LEN] = '{32'h0000_0000, 32'h0000_01AA,
                                             32'h0000_0000, 32'h4030_0000};

    always #50 clk = ~clk;

    // Board pull-up on the command line
    pullup (sd_cmd);

    sd_cmd_top #(
        .CLK_DIV_HALF (CLK_DIV_HALF),
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) sd_cmd_top_i (
        .clk          (clk),
        .rst_         (rst_),
        .start        (start),
        .sd_cmd       (sd_cmd),
        .sd_clk       (sd_clk),
        .resp_valid   (resp_valid),
        .resp_index   (resp_index),
        .resp_arg     (resp_arg),
        .resp_crc_ok  (resp_crc_ok),
        .resp_timeout (resp_timeout),
        .cmd_done     (cmd_done),
        .seq_done     (seq_done)
    );

    sd_card_model sd_card_model_i (
        .sd_clk      (sd_clk),
        .sd_cmd      (sd_cmd),
        .corrupt     (corrupt),
        .silent      (silent),
        .frame_count (frame_count),
        .rx_index    (rx_index),
        .rx_arg      (rx_arg),
        .rx_crc_ok   (rx_crc_ok),
        .rx_end_ok   (rx_end_ok)
    );

    // ========================================
    // Helpers
    // ========================================

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic compare_value(input int id, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("error %s: %s expected 0x%0h, actual 0x%0h",
                     test_names[id], what, expected, actual);
            errs[id]++;
        end
    endtask

    task automatic expect_true(input int id, input logic cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", test_names[id], msg);
            errs[id]++;
        end
    endtask

    task automatic report_test(input int id);
        $display("%-15s %s (%0d errors)", test_names[id], errs[id] == 0 ? "clean" : "ERRORS",
                 errs[id]);
    endtask

    // Collect response events up to cmd_done
    task automatic wait_command(input int k, output logic got_valid, output logic got_timeout,
                                output logic crc_ok, output cmd_index_t idx,
                                output cmd_arg_t arg);
        int   cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        got_valid = 1'b0;
        got_timeout = 1'b0;
        crc_ok = 1'b0;
        idx = '0;
        arg = '0;
        while (!done && cycles < CMD_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (resp_valid) begin
                got_valid = 1'b1;
                crc_ok = resp_crc_ok;
                idx = resp_index;
                arg = resp_arg;
            end
            if (resp_timeout) begin
                got_timeout = 1'b1;
            end
            done = cmd_done;
        end
        if (!done) begin
            $display("command %0d of the table did not finish within %0d clk cycles",
                     k, CMD_LIMIT);
            $display("Test failed");
            $finish;
        end
    endtask

    // One start pulse, then all table commands with per-command card flags
    task automatic run_init(input int id, input logic [3:0] corrupt_mask,
                            input logic [3:0] silent_mask);
        int         seq_before;
        int         frames_before;
        logic       got_valid;
        logic       got_timeout;
        logic       crc_ok;
        cmd_index_t idx;
        cmd_arg_t   arg;
        seq_before = seq_count;
        @(posedge clk);
        start <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int k = 0; k < INIT_TABLE_LEN; k++) begin
            corrupt <= corrupt_mask[k];
            silent <= silent_mask[k];
            frames_before = frame_count;
            wait_command(k, got_valid, got_timeout, crc_ok, idx, arg);
            // Frame as the card decoded it
            compare_value(T_FRAME, "frame count", frames_before + 1, frame_count);
            compare_value(T_FRAME, "index", exp_index[k], rx_index);
            compare_value(T_FRAME, "argument", exp_arg[k], rx_arg);
            expect_true(T_FRAME, rx_crc_ok, "card found a bad command CRC7");
            expect_true(T_FRAME, rx_end_ok, "card found a low end bit");
            if (exp_index[k] == CMD_GO_IDLE) begin
                expect_true(id, !got_valid && !got_timeout, "response event after CMD0");
            end else if (silent_mask[k]) begin
                expect_true(id, got_timeout && !got_valid, "silent card gave no timeout");
            end else begin
                expect_true(id, got_valid && !got_timeout, "answered command had no resp_valid");
                compare_value(id, "resp_index", exp_index[k], idx);
                compare_value(id, "resp_arg", exp_arg[k], arg);
                compare_value(id, "resp_crc_ok", !corrupt_mask[k], crc_ok);
            end
        end
        compare_value(id, "seq_done pulses", seq_before + 1, seq_count);
    endtask

    // ========================================
    // Monitors
    // ========================================

    // Quiet line and parked clock until start
    assert property (@(posedge clk) disable iff (!rst_ || started)
        !sd_clk && sd_cmd == 1'b1 && !resp_valid && !resp_timeout && !cmd_done && !seq_done)
    else begin
        $display("reset_state: DUT became active before start");
        errs[T_RESET]++;
    end

    // Phase lengths in clk cycles, parked low phases skipped
    always @(posedge clk) begin
        if (rst_) begin
            if (sd_clk != last_sd_clk) begin
                if (last_sd_clk || !low_parked) begin
                    compare_value(T_CLOCK, "sd_clk phase length", CLK_DIV_HALF, phase_len);
                end
                low_parked = cmd_done;
                phase_len = 1;
            end else begin
                phase_len++;
            end
            last_sd_clk = sd_clk;
            if (cmd_done) begin
                done_count++;
            end
            if (seq_done) begin
                seq_count++;
            end
        end
    end

    // End bit plus eight idle rising edges before the next start bit
    always @(posedge sd_clk) begin
        if (sd_cmd == 1'b0 && gap_checked != done_count) begin
            expect_true(T_CLOCK, quiet_rises >= 9, "fewer than eight idle sd_clk cycles");
            gap_checked = done_count;
        end
        if (sd_cmd == 1'b1) begin
            quiet_rises++;
        end else begin
            quiet_rises = 0;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        logic [3:0] corrupt_mask;
        logic [3:0] silent_mask;
        logic [1:0] pick;
        int         clean;
        int         total;
        rst_ = 1'b0;
        start = 1'b0;
        corrupt = 1'b0;
        silent = 1'b0;
        started = 1'b0;
        repeat (4) @(posedge clk);
        rst_ <= 1'b1;
        repeat (20) @(posedge clk);
        report_test(T_RESET);

        run_init(T_RESP, 4'b0000, 4'b0000);
        report_test(T_RESP);

        // Random corruption of the answered commands, at least one
        corrupt_mask = 4'b0000;
        for (int k = 1; k < INIT_TABLE_LEN; k++) begin
            corrupt_mask[k] = next_random_bit();
        end
        if (corrupt_mask == 4'b0000) begin
            corrupt_mask[INIT_TABLE_LEN - 1] = 1'b1;
        end
        run_init(T_CRC, corrupt_mask, 4'b0000);
        report_test(T_CRC);

        // One silent answered command
        pick[1] = next_random_bit();
        pick[0] = next_random_bit();
        silent_mask = 4'b0001 << (1 + pick % 3);
        run_init(T_TIMEOUT, 4'b0000, silent_mask);
        report_test(T_TIMEOUT);

        report_test(T_FRAME);
        report_test(T_CLOCK);

        clean = 0;
        total = 0;
        for (int i = 0; i < 6; i++) begin
            total += errs[i];
            if (errs[i] == 0) begin
                clean++;
            end
        end
        $display("%0d of 6 tests clean, %0d with errors, %0d errors in all",
                 clean, 6 - clean, total);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
common/sd_cmd_pkg.sv
sd_cmd/sd_crc7.sv
sd_cmd/sd_cmd_engine.sv
source/cmd_queue.sv
source/init_sequencer.sv
source/sd_cmd_top.sv
tb/sd_card_model.sv
tb/sd_cmd_tb.sv
